/* p2p_reg_pkg.sv */
`default_nettype none

package p2p_reg_pkg;

   // register bus widths
   localparam int axil_addr_width = 8;
   localparam int axil_data_width = 32;

   localparam logic [axil_data_width-1:0] p2p_id_value = 32'h5032_5001;

   // word offsets
   typedef enum logic [axil_addr_width-1:0] {
      reg_id       = 8'h00,
      reg_scratch  = 8'h04,
      reg_control  = 8'h08,
      reg_ts_latch = 8'h0C,
      reg_ts_lower = 8'h10,
      reg_ts_upper = 8'h14,
      reg_frames_0 = 8'h18,
      reg_frames_1 = 8'h1C
   } p2p_reg_e;

   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } axil_resp_e;

endpackage : p2p_reg_pkg

`default_nettype wire

/* p2p_stream_pkg.sv */
`default_nettype none

package p2p_stream_pkg;

   // defaults for the stream path
   localparam int default_data_width = 64;
   localparam int default_fifo_depth = 16;

   // frame gate states
   typedef enum logic [1:0] {
      gate_idle     = 2'd0,
      gate_in_frame = 2'd1,
      gate_paused   = 2'd2
   } gate_state_e;

endpackage : p2p_stream_pkg

`default_nettype wire

/* p2p_axil_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module p2p_axil_regs (
   input  logic                                   core_clk,
   input  logic                                   reset,

   input  logic [p2p_reg_pkg::axil_addr_width-1:0]   s_axil_awaddr,
   input  logic                                      s_axil_awvalid,
   output logic                                      s_axil_awready,
   input  logic [p2p_reg_pkg::axil_data_width-1:0]   s_axil_wdata,
   input  logic [p2p_reg_pkg::axil_data_width/8-1:0] s_axil_wstrb,
   input  logic                                      s_axil_wvalid,
   output logic                                      s_axil_wready,
   output logic [1:0]                                s_axil_bresp,
   output logic                                      s_axil_bvalid,
   input  logic                                      s_axil_bready,
   input  logic [p2p_reg_pkg::axil_addr_width-1:0]   s_axil_araddr,
   input  logic                                      s_axil_arvalid,
   output logic                                      s_axil_arready,
   output logic [p2p_reg_pkg::axil_data_width-1:0]   s_axil_rdata,
   output logic [1:0]                                s_axil_rresp,
   output logic                                      s_axil_rvalid,
   input  logic                                      s_axil_rready,

   input  logic [63:0]                               timestamp,
   input  logic [1:0]                                frame_done,
   output logic [1:0]                                pause
);

   import p2p_reg_pkg::*;

   localparam int strb_width = axil_data_width / 8;

   logic                       wr_en;
   logic                       rd_en;
   logic [axil_data_width-1:0] scratch;
   logic [63:0]                ts_latch;
   logic [axil_data_width-1:0] frame_cnt [2];
   axil_resp_e                 wr_resp;
   axil_resp_e                 rd_resp;
   logic [axil_data_width-1:0] rd_data;

   // ------------------------------------------------
   // write channel
   // ------------------------------------------------

   // address and data accepted together, one pending response
   assign wr_en          = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
   assign s_axil_awready = wr_en;
   assign s_axil_wready  = wr_en;

   always_comb begin
      case (s_axil_awaddr)
         reg_id, reg_scratch, reg_control, reg_ts_latch,
         reg_ts_lower, reg_ts_upper, reg_frames_0, reg_frames_1: begin
            wr_resp = resp_okay;
         end
         default: begin
            wr_resp = resp_slverr;
         end
      endcase
   end

   always_ff @(posedge core_clk) begin
      if (reset) begin
         scratch  <= '0;
         pause    <= '0;
         ts_latch <= '0;
      end else if (wr_en) begin
         case (s_axil_awaddr)
            reg_scratch: begin
               for (int i = 0; i < strb_width; i++) begin
                  if (s_axil_wstrb[i]) begin
                     scratch[8*i +: 8] <= s_axil_wdata[8*i +: 8];
                  end
               end
            end
            reg_control: begin
               if (s_axil_wstrb[0]) begin
                  pause <= s_axil_wdata[1:0];
               end
            end
            // capture the timestamp seen on the handshake cycle
            reg_ts_latch: begin
               ts_latch <= timestamp;
            end
            default: begin
            end
         endcase
      end
   end

   always_ff @(posedge core_clk) begin
      if (reset) begin
         s_axil_bvalid <= 1'b0;
      end else if (wr_en) begin
         s_axil_bvalid <= 1'b1;
      end else if (s_axil_bready) begin
         s_axil_bvalid <= 1'b0;
      end
   end

   always_ff @(posedge core_clk) begin
      if (wr_en) begin
         s_axil_bresp <= wr_resp;
      end
   end

   // ------------------------------------------------
   // read channel
   // ------------------------------------------------

   assign rd_en          = s_axil_arvalid && !s_axil_rvalid;
   assign s_axil_arready = rd_en;

   always_comb begin
      rd_data = '0;
      rd_resp = resp_okay;
      case (s_axil_araddr)
         reg_id:       rd_data = p2p_id_value;
         reg_scratch:  rd_data = scratch;
         reg_control:  rd_data[1:0] = pause;
         reg_ts_latch: rd_data = '0;
         reg_ts_lower: rd_data = ts_latch[31:0];
         reg_ts_upper: rd_data = ts_latch[63:32];
         reg_frames_0: rd_data = frame_cnt[0];
         reg_frames_1: rd_data = frame_cnt[1];
         default:      rd_resp = resp_slverr;
      endcase
   end

   always_ff @(posedge core_clk) begin
      if (reset) begin
         s_axil_rvalid <= 1'b0;
      end else if (rd_en) begin
         s_axil_rvalid <= 1'b1;
      end else if (s_axil_rready) begin
         s_axil_rvalid <= 1'b0;
      end
   end

   always_ff @(posedge core_clk) begin
      if (rd_en) begin
         s_axil_rdata <= rd_data;
         s_axil_rresp <= rd_resp;
      end
   end

   // forwarded frames per port, wrapping
   always_ff @(posedge core_clk) begin
      for (int i = 0; i < 2; i++) begin
         if (reset) begin
            frame_cnt[i] <= '0;
         end else if (frame_done[i]) begin
            frame_cnt[i] <= frame_cnt[i] + 1'b1;
         end
      end
   end

   // ------------------------------------------------
   // protocol checks
   // ------------------------------------------------

   assert property (@(posedge core_clk) disable iff (reset)
      s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);

   assert property (@(posedge core_clk) disable iff (reset)
      s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid);

   assert property (@(posedge core_clk) disable iff (reset)
      s_axil_awready |=> s_axil_bvalid && !s_axil_awready);

endmodule : p2p_axil_regs

`default_nettype wire

/* p2p_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module p2p_fifo #(
   parameter int DATA_WIDTH = p2p_stream_pkg::default_data_width,
   parameter int FIFO_DEPTH = p2p_stream_pkg::default_fifo_depth
) (
   input  logic                    core_clk,
   input  logic                    reset,

   input  logic [DATA_WIDTH-1:0]   in_tdata,
   input  logic [DATA_WIDTH/8-1:0] in_tkeep,
   input  logic                    in_tlast,
   input  logic                    in_tvalid,
   output logic                    in_tready,

   output logic [DATA_WIDTH-1:0]   out_tdata,
   output logic [DATA_WIDTH/8-1:0] out_tkeep,
   output logic                    out_tlast,
   output logic                    out_tvalid,
   input  logic                    out_tready
);

   localparam int addr_width = $clog2(FIFO_DEPTH);
   localparam int beat_width = DATA_WIDTH + DATA_WIDTH/8 + 1;
   localparam logic [addr_width:0] full_count = (addr_width+1)'(FIFO_DEPTH);

   logic [beat_width-1:0] mem [FIFO_DEPTH];
   logic [addr_width-1:0] wr_ptr;
   logic [addr_width-1:0] rd_ptr;
   logic [addr_width:0]   count;
   logic                  wr_en;
   logic                  rd_en;

   assign in_tready  = (count != full_count);
   assign out_tvalid = (count != '0);
   assign wr_en      = in_tvalid && in_tready;
   assign rd_en      = out_tvalid && out_tready;

   // head of queue drives the output directly
   assign {out_tlast, out_tkeep, out_tdata} = mem[rd_ptr];

   always_ff @(posedge core_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= {in_tlast, in_tkeep, in_tdata};
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge core_clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // overflow and underflow
   assert property (@(posedge core_clk) disable iff (reset)
      count == full_count |-> !wr_en);

   assert property (@(posedge core_clk) disable iff (reset)
      count == '0 |-> !rd_en);

endmodule : p2p_fifo

`default_nettype wire

/* p2p_frame_gate.sv */
`timescale 1ns/10ps
`default_nettype none

module p2p_frame_gate #(
   parameter int DATA_WIDTH = p2p_stream_pkg::default_data_width
) (
   input  logic                    core_clk,
   input  logic                    reset,
   input  logic                    pause,

   input  logic [DATA_WIDTH-1:0]   in_tdata,
   input  logic [DATA_WIDTH/8-1:0] in_tkeep,
   input  logic                    in_tlast,
   input  logic                    in_tvalid,
   output logic                    in_tready,

   output logic [DATA_WIDTH-1:0]   out_tdata,
   output logic [DATA_WIDTH/8-1:0] out_tkeep,
   output logic                    out_tlast,
   output logic                    out_tvalid,
   input  logic                    out_tready,

   output logic                    frame_done
);

   import p2p_stream_pkg::*;

   gate_state_e state;
   logic        open;
   logic        xfer;

   // between frames a raised pause closes the gate at once
   assign open = (state == gate_in_frame) || (state == gate_idle && !pause);

   assign out_tvalid = in_tvalid && open;
   assign in_tready  = out_tready && open;
   assign out_tdata  = in_tdata;
   assign out_tkeep  = in_tkeep;
   assign out_tlast  = in_tlast;
   assign xfer       = out_tvalid && out_tready;

   always_ff @(posedge core_clk) begin
      if (reset) begin
         state      <= gate_idle;
         frame_done <= 1'b0;
      end else begin
         frame_done <= xfer && in_tlast;
         case (state)
            gate_idle: begin
               if (pause) begin
                  state <= gate_paused;
               end else if (xfer && !in_tlast) begin
                  state <= gate_in_frame;
               end
            end
            // pause ignored until the frame ends
            gate_in_frame: begin
               if (xfer && in_tlast) begin
                  state <= gate_idle;
               end
            end
            gate_paused: begin
               if (!pause) begin
                  state <= gate_idle;
               end
            end
            default: begin
               state <= gate_idle;
            end
         endcase
      end
   end

   assert property (@(posedge core_clk) disable iff (reset)
      state == gate_paused |-> !out_tvalid);

endmodule : p2p_frame_gate

`default_nettype wire

/* p2p.sv */
`timescale 1ns/10ps
`default_nettype none

module p2p #(
   parameter int DATA_WIDTH = p2p_stream_pkg::default_data_width,
   parameter int FIFO_DEPTH = p2p_stream_pkg::default_fifo_depth
) (
   input  logic                                      core_clk,
   input  logic                                      reset,
   input  logic [63:0]                               timestamp,

   input  logic [p2p_reg_pkg::axil_addr_width-1:0]   s_axil_awaddr,
   input  logic                                      s_axil_awvalid,
   output logic                                      s_axil_awready,
   input  logic [p2p_reg_pkg::axil_data_width-1:0]   s_axil_wdata,
   input  logic [p2p_reg_pkg::axil_data_width/8-1:0] s_axil_wstrb,
   input  logic                                      s_axil_wvalid,
   output logic                                      s_axil_wready,
   output logic [1:0]                                s_axil_bresp,
   output logic                                      s_axil_bvalid,
   input  logic                                      s_axil_bready,
   input  logic [p2p_reg_pkg::axil_addr_width-1:0]   s_axil_araddr,
   input  logic                                      s_axil_arvalid,
   output logic                                      s_axil_arready,
   output logic [p2p_reg_pkg::axil_data_width-1:0]   s_axil_rdata,
   output logic [1:0]                                s_axil_rresp,
   output logic                                      s_axil_rvalid,
   input  logic                                      s_axil_rready,

   input  logic [DATA_WIDTH-1:0]                     in0_tdata,
   input  logic [DATA_WIDTH/8-1:0]                   in0_tkeep,
   input  logic                                      in0_tlast,
   input  logic                                      in0_tvalid,
   output logic                                      in0_tready,
   output logic [DATA_WIDTH-1:0]                     out0_tdata,
   output logic [DATA_WIDTH/8-1:0]                   out0_tkeep,
   output logic                                      out0_tlast,
   output logic                                      out0_tvalid,
   input  logic                                      out0_tready,

   input  logic [DATA_WIDTH-1:0]                     in1_tdata,
   input  logic [DATA_WIDTH/8-1:0]                   in1_tkeep,
   input  logic                                      in1_tlast,
   input  logic                                      in1_tvalid,
   output logic                                      in1_tready,
   output logic [DATA_WIDTH-1:0]                     out1_tdata,
   output logic [DATA_WIDTH/8-1:0]                   out1_tkeep,
   output logic                                      out1_tlast,
   output logic                                      out1_tvalid,
   input  logic                                      out1_tready
);

   logic [1:0]              pause;
   logic [1:0]              frame_done;

   // fifo to gate, per port
   logic [DATA_WIDTH-1:0]   fifo0_tdata;
   logic [DATA_WIDTH/8-1:0] fifo0_tkeep;
   logic                    fifo0_tlast;
   logic                    fifo0_tvalid;
   logic                    fifo0_tready;
   logic [DATA_WIDTH-1:0]   fifo1_tdata;
   logic [DATA_WIDTH/8-1:0] fifo1_tkeep;
   logic                    fifo1_tlast;
   logic                    fifo1_tvalid;
   logic                    fifo1_tready;

   // ------------------------------------------------
   // control plane
   // ------------------------------------------------

   p2p_axil_regs i_p2p_axil_regs (
      .core_clk       (core_clk),
      .reset          (reset),
      .s_axil_awaddr  (s_axil_awaddr),
      .s_axil_awvalid (s_axil_awvalid),
      .s_axil_awready (s_axil_awready),
      .s_axil_wdata   (s_axil_wdata),
      .s_axil_wstrb   (s_axil_wstrb),
      .s_axil_wvalid  (s_axil_wvalid),
      .s_axil_wready  (s_axil_wready),
      .s_axil_bresp   (s_axil_bresp),
      .s_axil_bvalid  (s_axil_bvalid),
      .s_axil_bready  (s_axil_bready),
      .s_axil_araddr  (s_axil_araddr),
      .s_axil_arvalid (s_axil_arvalid),
      .s_axil_arready (s_axil_arready),
      .s_axil_rdata   (s_axil_rdata),
      .s_axil_rresp   (s_axil_rresp),
      .s_axil_rvalid  (s_axil_rvalid),
      .s_axil_rready  (s_axil_rready),
      .timestamp      (timestamp),
      .frame_done     (frame_done),
      .pause          (pause)
   );

   // ------------------------------------------------
   // port 0 stream path
   // ------------------------------------------------

   p2p_fifo #(
      .DATA_WIDTH (DATA_WIDTH),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_p2p_fifo_0 (
      .core_clk   (core_clk),
      .reset      (reset),
      .in_tdata   (in0_tdata),
      .in_tkeep   (in0_tkeep),
      .in_tlast   (in0_tlast),
      .in_tvalid  (in0_tvalid),
      .in_tready  (in0_tready),
      .out_tdata  (fifo0_tdata),
      .out_tkeep  (fifo0_tkeep),
      .out_tlast  (fifo0_tlast),
      .out_tvalid (fifo0_tvalid),
      .out_tready (fifo0_tready)
   );

   p2p_frame_gate #(
      .DATA_WIDTH (DATA_WIDTH)
   ) i_p2p_frame_gate_0 (
      .core_clk   (core_clk),
      .reset      (reset),
      .pause      (pause[0]),
      .in_tdata   (fifo0_tdata),
      .in_tkeep   (fifo0_tkeep),
      .in_tlast   (fifo0_tlast),
      .in_tvalid  (fifo0_tvalid),
      .in_tready  (fifo0_tready),
      .out_tdata  (out0_tdata),
      .out_tkeep  (out0_tkeep),
      .out_tlast  (out0_tlast),
      .out_tvalid (out0_tvalid),
      .out_tready (out0_tready),
      .frame_done (frame_done[0])
   );

   // ------------------------------------------------
   // port 1 stream path
   // ------------------------------------------------

   p2p_fifo #(
      .DATA_WIDTH (DATA_WIDTH),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_p2p_fifo_1 (
      .core_clk   (core_clk),
      .reset      (reset),
      .in_tdata   (in1_tdata),
      .in_tkeep   (in1_tkeep),
      .in_tlast   (in1_tlast),
      .in_tvalid  (in1_tvalid),
      .in_tready  (in1_tready),
      .out_tdata  (fifo1_tdata),
      .out_tkeep  (fifo1_tkeep),
      .out_tlast  (fifo1_tlast),
      .out_tvalid (fifo1_tvalid),
      .out_tready (fifo1_tready)
   );

   p2p_frame_gate #(
      .DATA_WIDTH (DATA_WIDTH)
   ) i_p2p_frame_gate_1 (
      .core_clk   (core_clk),
      .reset      (reset),
      .pause      (pause[1]),
      .in_tdata   (fifo1_tdata),
      .in_tkeep   (fifo1_tkeep),
      .in_tlast   (fifo1_tlast),
      .in_tvalid  (fifo1_tvalid),
      .in_tready  (fifo1_tready),
      .out_tdata  (out1_tdata),
      .out_tkeep  (out1_tkeep),
      .out_tlast  (out1_tlast),
      .out_tvalid (out1_tvalid),
      .out_tready (out1_tready),
      .frame_done (frame_done[1])
   );

endmodule : p2p

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 2
) (
   output logic core_clk,
   output logic reset
);

   initial begin
      core_clk = 1'b0;
      forever #(PERIOD_NS / 2) core_clk = ~core_clk;
   end

   // reset released on a rising edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge core_clk);
      reset <= 1'b0;
   end

endmodule : tb_clock

`default_nettype wire

/* p2p_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module p2p_tb;

   import p2p_reg_pkg::*;
   import p2p_stream_pkg::*;

   localparam int data_w       = default_data_width;
   localparam int keep_w       = data_w / 8;
   localparam int num_frames   = 6;
   localparam int pause_hold   = 60;
   localparam int reg_accesses = 12;
   // longest frames, both phases, both ports
   localparam int beat_budget    = 2 * num_frames * (8 + 15);
   localparam int timeout_cycles = (beat_budget + reg_accesses) * 20;

   typedef logic [data_w+keep_w:0] beat_t;

   logic                       core_clk;
   logic                       reset;
   logic [63:0]                timestamp;
   logic [axil_addr_width-1:0] s_axil_awaddr;
   logic                       s_axil_awvalid;
   logic                       s_axil_awready;
   logic [axil_data_width-1:0] s_axil_wdata;
   logic [3:0]                 s_axil_wstrb;
   logic                       s_axil_wvalid;
   logic                       s_axil_wready;
   logic [1:0]                 s_axil_bresp;
   logic                       s_axil_bvalid;
   logic                       s_axil_bready;
   logic [axil_addr_width-1:0] s_axil_araddr;
   logic                       s_axil_arvalid;
   logic                       s_axil_arready;
   logic [axil_data_width-1:0] s_axil_rdata;
   logic [1:0]                 s_axil_rresp;
   logic                       s_axil_rvalid;
   logic                       s_axil_rready;

   logic [data_w-1:0] in_tdata [2];
   logic [keep_w-1:0] in_tkeep [2];
   logic [1:0]        in_tlast;
   logic [1:0]        in_tvalid;
   logic [1:0]        in_tready;
   logic [data_w-1:0] out_tdata [2];
   logic [keep_w-1:0] out_tkeep [2];
   logic [1:0]        out_tlast;
   logic [1:0]        out_tvalid;
   logic [1:0]        out_tready;

   int          seed = 56;
   beat_t       exp_q [2][$];
   int          frames_seen [2];
   logic [1:0]  out_in_frame;
   logic        pause_active;
   int          paused_beats_1;
   logic [63:0] ts_at_write;

   tb_clock i_tb_clock (
      .core_clk (core_clk),
      .reset    (reset)
   );

   p2p #(
      .DATA_WIDTH (data_w),
      .FIFO_DEPTH (default_fifo_depth)
   ) i_p2p (
      .*,
      .in0_tdata   (in_tdata[0]),
      .in0_tkeep   (in_tkeep[0]),
      .in0_tlast   (in_tlast[0]),
      .in0_tvalid  (in_tvalid[0]),
      .in0_tready  (in_tready[0]),
      .out0_tdata  (out_tdata[0]),
      .out0_tkeep  (out_tkeep[0]),
      .out0_tlast  (out_tlast[0]),
      .out0_tvalid (out_tvalid[0]),
      .out0_tready (out_tready[0]),
      .in1_tdata   (in_tdata[1]),
      .in1_tkeep   (in_tkeep[1]),
      .in1_tlast   (in_tlast[1]),
      .in1_tvalid  (in_tvalid[1]),
      .in1_tready  (in_tready[1]),
      .out1_tdata  (out_tdata[1]),
      .out1_tkeep  (out_tkeep[1]),
      .out1_tlast  (out_tlast[1]),
      .out1_tvalid (out_tvalid[1]),
      .out1_tready (out_tready[1])
   );

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      assert (got === want)
         else report_error($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, want));
   endtask

   task automatic axil_write(input logic [axil_addr_width-1:0] addr,
                             input logic [axil_data_width-1:0] data,
                             output logic [1:0] resp);
      s_axil_awaddr  <= addr;
      s_axil_wdata   <= data;
      s_axil_wstrb   <= 4'hF;
      s_axil_awvalid <= 1'b1;
      s_axil_wvalid  <= 1'b1;
      do @(posedge core_clk); while (!s_axil_awready);
      check_value("s_axil_wready", 64'(s_axil_wready), 64'h1);
      // timestamp the register block samples on this edge
      ts_at_write     = timestamp;
      s_axil_awvalid <= 1'b0;
      s_axil_wvalid  <= 1'b0;
      s_axil_bready  <= 1'b1;
      do @(posedge core_clk); while (!s_axil_bvalid);
      s_axil_bready <= 1'b0;
      resp = s_axil_bresp;
   endtask

   task automatic axil_read(input logic [axil_addr_width-1:0] addr,
                            output logic [axil_data_width-1:0] data,
                            output logic [1:0] resp);
      s_axil_araddr  <= addr;
      s_axil_arvalid <= 1'b1;
      do @(posedge core_clk); while (!s_axil_arready);
      s_axil_arvalid <= 1'b0;
      s_axil_rready  <= 1'b1;
      do @(posedge core_clk); while (!s_axil_rvalid);
      s_axil_rready <= 1'b0;
      data = s_axil_rdata;
      resp = s_axil_rresp;
   endtask

   // frames of min_len to min_len+7 beats, valid held until accepted
   task automatic send_frames(input int port, input int count, input int min_len);
      int len;
      for (int f = 0; f < count; f++) begin
         len = min_len + ($random(seed) & 7);
         for (int i = 0; i < len; i++) begin
            in_tdata[port]  <= data_w'({$random(seed), $random(seed)});
            in_tkeep[port]  <= (i == len - 1) ? {keep_w{1'b1}} >> ($random(seed) & 7) : '1;
            in_tlast[port]  <= (i == len - 1);
            in_tvalid[port] <= 1'b1;
            do @(posedge core_clk); while (!in_tready[port]);
         end
      end
      in_tvalid[port] <= 1'b0;
   endtask

   // counters settle two edges after the last tlast
   task automatic wait_drained();
      do @(negedge core_clk); while (exp_q[0].size() != 0 || exp_q[1].size() != 0);
      repeat (2) @(posedge core_clk);
   endtask

   // --------------------------------------------------
   // free-running sources and output checks
   // --------------------------------------------------

   always @(posedge core_clk) begin
      timestamp  <= timestamp + 64'd1;
      out_tready <= {(($random(seed) & 3) != 0), (($random(seed) & 3) != 0)};
   end

   always @(posedge core_clk) begin
      beat_t want;
      if (!reset) begin
         for (int p = 0; p < 2; p++) begin
            if (in_tvalid[p] && in_tready[p]) begin
               exp_q[p].push_back({in_tlast[p], in_tkeep[p], in_tdata[p]});
            end
            if (out_tvalid[p] && out_tready[p]) begin
               assert (exp_q[p].size() > 0)
                  else report_error($sformatf("beat on out%0d with nothing left to expect", p));
               want = exp_q[p].pop_front();
               check_value($sformatf("out%0d_tdata", p), 64'(out_tdata[p]),
                           64'(want[data_w-1:0]));
               check_value($sformatf("out%0d_tkeep", p), 64'(out_tkeep[p]),
                           64'(want[data_w +: keep_w]));
               check_value($sformatf("out%0d_tlast", p), 64'(out_tlast[p]),
                           64'(want[data_w+keep_w]));
               out_in_frame[p] <= !out_tlast[p];
               if (out_tlast[p]) begin
                  frames_seen[p] <= frames_seen[p] + 1;
               end
               if (p == 1 && pause_active) begin
                  paused_beats_1 <= paused_beats_1 + 1;
               end
            end
         end
         // port 0 closed once its open frame is done
         if (pause_active && !out_in_frame[0]) begin
            check_value("out0_tvalid", 64'(out_tvalid[0]), 64'h0);
         end
      end
   end

   initial begin
      repeat (timeout_cycles) @(posedge core_clk);
      report_error($sformatf("watchdog expired after %0d cycles, run did not finish",
                             timeout_cycles));
   end

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------

   initial begin
      logic [1:0]                 resp;
      logic [axil_data_width-1:0] rdata;
      logic [63:0]                ts_expect;
      timestamp      = 64'h0000_0001_ffff_ff00;
      s_axil_awaddr  = '0;
      s_axil_awvalid = 1'b0;
      s_axil_wdata   = '0;
      s_axil_wstrb   = '0;
      s_axil_wvalid  = 1'b0;
      s_axil_bready  = 1'b0;
      s_axil_araddr  = '0;
      s_axil_arvalid = 1'b0;
      s_axil_rready  = 1'b0;
      for (int p = 0; p < 2; p++) begin
         in_tdata[p]    = '0;
         in_tkeep[p]    = '0;
         frames_seen[p] = 0;
      end
      in_tlast       = '0;
      in_tvalid      = '0;
      out_tready     = '0;
      out_in_frame   = '0;
      pause_active   = 1'b0;
      paused_beats_1 = 0;
      do @(posedge core_clk); while (reset);

      axil_read(reg_id, rdata, resp);
      check_value("s_axil_rdata", 64'(rdata), 64'(p2p_id_value));
      check_value("s_axil_rresp", 64'(resp), 64'(resp_okay));
      axil_write(reg_scratch, 32'ha5c3_0f96, resp);
      check_value("s_axil_bresp", 64'(resp), 64'(resp_okay));
      axil_read(reg_scratch, rdata, resp);
      check_value("s_axil_rdata", 64'(rdata), 64'ha5c3_0f96);
      // nothing mapped at 0x40
      axil_read(8'h40, rdata, resp);
      check_value("s_axil_rdata", 64'(rdata), 64'h0);
      check_value("s_axil_rresp", 64'(resp), 64'(resp_slverr));
      axil_write(8'h40, 32'hffff_ffff, resp);
      check_value("s_axil_bresp", 64'(resp), 64'(resp_slverr));

      axil_write(reg_ts_latch, 32'h1, resp);
      ts_expect = ts_at_write;
      axil_read(reg_ts_lower, rdata, resp);
      check_value("reg_ts_lower", 64'(rdata), 64'(ts_expect[31:0]));
      axil_read(reg_ts_upper, rdata, resp);
      check_value("reg_ts_upper", 64'(rdata), 64'(ts_expect[63:32]));

      fork
         send_frames(0, num_frames, 1);
         send_frames(1, num_frames, 1);
      join
      wait_drained();

      // long frames so the pause lands mid-frame
      fork
         send_frames(0, num_frames, 8);
         send_frames(1, num_frames, 8);
         begin
            do @(negedge core_clk); while (!out_in_frame[0]);
            @(posedge core_clk);
            axil_write(reg_control, 32'h1, resp);
            pause_active <= 1'b1;
            repeat (pause_hold) @(posedge core_clk);
            assert (!out_in_frame[0])
               else report_error("port 0 still inside a frame after the pause hold");
            assert (paused_beats_1 > 0)
               else report_error("port 1 forwarded nothing while port 0 was paused");
            pause_active <= 1'b0;
            axil_write(reg_control, 32'h0, resp);
         end
      join
      wait_drained();

      axil_read(reg_frames_0, rdata, resp);
      check_value("reg_frames_0", 64'(rdata), 64'(frames_seen[0]));
      axil_read(reg_frames_1, rdata, resp);
      check_value("reg_frames_1", 64'(rdata), 64'(frames_seen[1]));

      $display("Testbench passed");
      $finish;
   end

endmodule : p2p_tb

`default_nettype wire

/* p2p.f */
p2p_reg_pkg.sv
p2p_stream_pkg.sv
p2p_axil_regs.sv
p2p_fifo.sv
p2p_frame_gate.sv
p2p.sv
tb_clock.sv
p2p_tb.sv

/* Makefile */
SHELL := /bin/bash

VERILATOR ?= verilator
FILELIST  ?= p2p.f
TOP       ?= p2p_tb
LINT_TOP  ?= p2p
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SRCS := $(wildcard *.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/10ps -f $(FILELIST) \
		--top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
